// ==== common/cpu_pkg.sv ====
package cpu_pkg;

  // ==============================
  // Widths and word types
  // ==============================
  localparam int DATA_WIDTH    = 32;
  localparam int INST_WIDTH    = 32;
  localparam int RF_ADDR_WIDTH = 5;

  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [INST_WIDTH-1:0]    inst_t;
  typedef logic [RF_ADDR_WIDTH-1:0] reg_idx_t;

  // ==============================
  // Opcodes and control encodings
  // ==============================
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // LINK yields pc + 4 for JAL and JALR
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B,
    ALU_LINK
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_JAL,
    BR_JALR
  } branch_e;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  // ==============================
  // Exception vector
  // ==============================
  localparam int EXC_WIDTH  = 5;
  localparam int EXC_FETCH  = 0;
  localparam int EXC_DECODE = 1;
  localparam int EXC_MEM    = 2;
  localparam int EXC_ECALL  = 3;
  localparam int EXC_EBREAK = 4;

  // ADDI x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

endpackage

// ==== hw/mem_control.sv ====
`timescale 1ns/1ps

module mem_control
  import cpu_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic  clk_i,
  input  data_t pc_i,
  input  data_t addr_i,
  input  data_t wdata_i,
  input  logic  rd_en_i,
  input  logic  wr_en_i,
  input  logic  prog_we_i,
  input  data_t prog_addr_i,
  input  inst_t prog_data_i,
  output inst_t inst_o,
  output data_t rdata_o,
  output logic  inst_fault_o,
  output logic  data_fault_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  data_t            mem [MEM_WORDS];
  logic [IDX_W-1:0] inst_idx;
  logic [IDX_W-1:0] data_idx;
  logic [IDX_W-1:0] prog_idx;

  // Byte addresses, word granular storage
  assign inst_idx = pc_i[IDX_W+1:2];
  assign data_idx = addr_i[IDX_W+1:2];
  assign prog_idx = prog_addr_i[IDX_W+1:2];

  assign inst_fault_o = (pc_i >> 2) >= data_t'(MEM_WORDS);

  // Only word accesses, so any low address bit set is misaligned
  assign data_fault_o = (rd_en_i | wr_en_i) &
                        ((addr_i[1:0] != 2'b00) | ((addr_i >> 2) >= data_t'(MEM_WORDS)));

  always_ff @(posedge clk_i) begin
    if (prog_we_i) begin
      mem[prog_idx] <= prog_data_i;
    end else if (wr_en_i && !data_fault_o) begin
      mem[data_idx] <= wdata_i;
    end

    // A fetch outside the array decodes as a no-op
    inst_o <= inst_fault_o ? NOP_INST : mem[inst_idx];

    if (rd_en_i) begin
      rdata_o <= mem[data_idx];
    end
  end

endmodule

// ==== core/gpr.sv ====
`timescale 1ns/1ps

module gpr
  import cpu_pkg::*;
(
  input  logic     clk_i,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  input  reg_idx_t rd_i,
  input  logic     we_i,
  input  data_t    wdata_i,
  output data_t    rs1_data_o,
  output data_t    rs2_data_o
);

  localparam int NUM_REGS = 2 ** RF_ADDR_WIDTH;

  data_t regs [NUM_REGS];

  // x0 reads zero, a same-cycle WB write bypasses the array
  function automatic data_t read_port(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (we_i && rd_i == idx) begin
      return wdata_i;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk_i) begin
    if (we_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

endmodule

// ==== core/idu.sv ====
`timescale 1ns/1ps

module idu
  import cpu_pkg::*;
(
  input  inst_t    inst_i,
  output reg_idx_t rs1_o,
  output reg_idx_t rs2_o,
  output reg_idx_t rd_o,
  output logic     use_rs1_o,
  output logic     use_rs2_o,
  output logic     reg_we_o,
  output logic     mem_rd_o,
  output logic     mem_wr_o,
  output logic     alu_src_imm_o,
  output alu_op_e  alu_op_o,
  output branch_e  branch_o,
  output data_t    imm_o,
  output logic     decode_error_o,
  output logic     ecall_o,
  output logic     ebreak_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  data_t      imm_i_fmt;
  data_t      imm_s_fmt;
  data_t      imm_b_fmt;
  data_t      imm_j_fmt;
  logic       illegal;

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  assign rs1_o = inst_i[19:15];
  assign rs2_o = inst_i[24:20];
  assign rd_o  = inst_i[11:7];

  // Immediate formats, all sign extended from bit 31
  assign imm_i_fmt = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_fmt = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b_fmt = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                      inst_i[11:8], 1'b0};
  assign imm_j_fmt = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                      inst_i[30:21], 1'b0};

  always_comb begin
    use_rs1_o     = 1'b0;
    use_rs2_o     = 1'b0;
    reg_we_o      = 1'b0;
    mem_rd_o      = 1'b0;
    mem_wr_o      = 1'b0;
    alu_src_imm_o = 1'b0;
    alu_op_o      = ALU_PASS_B;
    branch_o      = BR_NONE;
    imm_o         = imm_i_fmt;
    ecall_o       = 1'b0;
    ebreak_o      = 1'b0;
    illegal       = 1'b0;

    case (opcode)
      OPC_OP: begin
        use_rs1_o = 1'b1;
        use_rs2_o = 1'b1;
        reg_we_o  = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op_o = ALU_ADD;
          10'b0100000_000: alu_op_o = ALU_SUB;
          10'b0000000_111: alu_op_o = ALU_AND;
          10'b0000000_110: alu_op_o = ALU_OR;
          10'b0000000_100: alu_op_o = ALU_XOR;
          10'b0000000_010: alu_op_o = ALU_SLT;
          default:         illegal  = 1'b1;
        endcase
      end
      // ADDI only
      OPC_OP_IMM: begin
        use_rs1_o     = 1'b1;
        reg_we_o      = 1'b1;
        alu_src_imm_o = 1'b1;
        alu_op_o      = ALU_ADD;
        illegal       = (funct3 != 3'b000);
      end
      OPC_LOAD: begin
        use_rs1_o     = 1'b1;
        reg_we_o      = 1'b1;
        mem_rd_o      = 1'b1;
        alu_src_imm_o = 1'b1;
        alu_op_o      = ALU_ADD;
        illegal       = (funct3 != 3'b010);
      end
      OPC_STORE: begin
        use_rs1_o     = 1'b1;
        use_rs2_o     = 1'b1;
        mem_wr_o      = 1'b1;
        alu_src_imm_o = 1'b1;
        alu_op_o      = ALU_ADD;
        imm_o         = imm_s_fmt;
        illegal       = (funct3 != 3'b010);
      end
      OPC_BRANCH: begin
        use_rs1_o = 1'b1;
        use_rs2_o = 1'b1;
        imm_o     = imm_b_fmt;
        case (funct3)
          3'b000:  branch_o = BR_BEQ;
          3'b001:  branch_o = BR_BNE;
          default: illegal  = 1'b1;
        endcase
      end
      OPC_JAL: begin
        reg_we_o = 1'b1;
        alu_op_o = ALU_LINK;
        branch_o = BR_JAL;
        imm_o    = imm_j_fmt;
      end
      OPC_JALR: begin
        use_rs1_o = 1'b1;
        reg_we_o  = 1'b1;
        alu_op_o  = ALU_LINK;
        branch_o  = BR_JALR;
        illegal   = (funct3 != 3'b000);
      end
      OPC_SYSTEM: begin
        ecall_o  = (inst_i == 32'h0000_0073);
        ebreak_o = (inst_i == 32'h0010_0073);
        illegal  = ~(ecall_o | ebreak_o);
      end
      default: illegal = 1'b1;
    endcase

    // Unknown encodings run as a no-op
    if (illegal) begin
      use_rs1_o     = 1'b0;
      use_rs2_o     = 1'b0;
      reg_we_o      = 1'b0;
      mem_rd_o      = 1'b0;
      mem_wr_o      = 1'b0;
      alu_src_imm_o = 1'b0;
      alu_op_o      = ALU_PASS_B;
      branch_o      = BR_NONE;
    end
  end

  assign decode_error_o = illegal;

endmodule

// ==== core/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
  import cpu_pkg::*;
(
  input  data_t   a_i,
  input  data_t   b_i,
  input  alu_op_e alu_op_i,
  input  branch_e branch_i,
  input  data_t   pc_i,
  input  data_t   imm_i,
  input  data_t   rs1_val_i,
  input  data_t   rs2_val_i,
  output data_t   result_o,
  output logic    redirect_o,
  output data_t   target_o
);

  data_t jalr_sum;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_OR:     result_o = a_i | b_i;
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SLT:    result_o = data_t'($signed(a_i) < $signed(b_i));
      ALU_PASS_B: result_o = b_i;
      default:    result_o = pc_i + data_t'(4);
    endcase
  end

  // Not-taken is the prediction, so any taken transfer redirects
  always_comb begin
    case (branch_i)
      BR_BEQ:           redirect_o = (rs1_val_i == rs2_val_i);
      BR_BNE:           redirect_o = (rs1_val_i != rs2_val_i);
      BR_JAL, BR_JALR:  redirect_o = 1'b1;
      default:          redirect_o = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_val_i + imm_i;
  assign target_o = (branch_i == BR_JALR) ? {jalr_sum[DATA_WIDTH-1:1], 1'b0} : pc_i + imm_i;

endmodule

// ==== core/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit
  import cpu_pkg::*;
(
  input  reg_idx_t ex_rs1_i,
  input  reg_idx_t ex_rs2_i,
  input  logic     ex_use_rs1_i,
  input  logic     ex_use_rs2_i,
  input  reg_idx_t mem_rd_i,
  input  logic     mem_we_i,
  input  reg_idx_t wb_rd_i,
  input  logic     wb_we_i,
  input  logic     ex_load_i,
  input  reg_idx_t ex_rd_i,
  input  reg_idx_t id_rs1_i,
  input  reg_idx_t id_rs2_i,
  input  logic     id_use_rs1_i,
  input  logic     id_use_rs2_i,
  input  logic     redirect_i,
  output fwd_sel_e fwd_a_o,
  output fwd_sel_e fwd_b_o,
  output logic     stall_o,
  output logic     flush_o
);

  logic load_use;

  // Youngest producer wins, MEM before WB
  function automatic fwd_sel_e pick_source(reg_idx_t rs, logic use_rs);
    if (!use_rs || rs == '0) begin
      return FWD_NONE;
    end else if (mem_we_i && mem_rd_i == rs) begin
      return FWD_MEM;
    end else if (wb_we_i && wb_rd_i == rs) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  always_comb begin
    fwd_a_o = pick_source(ex_rs1_i, ex_use_rs1_i);
    fwd_b_o = pick_source(ex_rs2_i, ex_use_rs2_i);
  end

  // Load data only reaches WB, so a consumer right behind it waits a cycle
  assign load_use = ex_load_i & (ex_rd_i != '0) &
                    ((id_use_rs1_i & (id_rs1_i == ex_rd_i)) |
                     (id_use_rs2_i & (id_rs2_i == ex_rd_i)));

  assign stall_o = load_use & ~redirect_i;
  assign flush_o = redirect_i;

endmodule

// ==== core/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
  import cpu_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  data_t                pc_i,
  input  logic                 prog_we_i,
  input  data_t                prog_addr_i,
  input  inst_t                prog_data_i,
  output data_t                new_pc_o,
  output logic                 wb_valid_o,
  output reg_idx_t             wb_rd_o,
  output data_t                wb_data_o,
  output logic [EXC_WIDTH-1:0] exceptions_o
);

  // Pipeline control
  logic     stall;
  logic     flush;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;

  // Fetch and ID
  inst_t                inst_raw;
  logic                 inst_fault;
  logic                 stall_q;
  logic                 flush_q;
  logic                 id_valid_q;
  logic                 id_fault_q;
  data_t                id_pc_q;
  inst_t                id_hold_q;
  inst_t                id_inst;
  logic                 id_valid;
  reg_idx_t             id_rs1;
  reg_idx_t             id_rs2;
  reg_idx_t             id_rd;
  logic                 id_use_rs1;
  logic                 id_use_rs2;
  logic                 id_reg_we;
  logic                 id_mem_rd;
  logic                 id_mem_wr;
  logic                 id_alu_src_imm;
  alu_op_e              id_alu_op;
  branch_e              id_branch;
  data_t                id_imm;
  logic                 id_decode_error;
  logic                 id_ecall;
  logic                 id_ebreak;
  data_t                id_rs1_data;
  data_t                id_rs2_data;
  logic [EXC_WIDTH-1:0] id_exc;

  // EX
  logic                 ex_valid;
  data_t                ex_pc;
  data_t                ex_imm;
  data_t                ex_rs1_data;
  data_t                ex_rs2_data;
  reg_idx_t             ex_rs1;
  reg_idx_t             ex_rs2;
  reg_idx_t             ex_rd;
  logic                 ex_use_rs1;
  logic                 ex_use_rs2;
  logic                 ex_reg_we;
  logic                 ex_mem_rd;
  logic                 ex_mem_wr;
  logic                 ex_alu_src_imm;
  alu_op_e              ex_alu_op;
  branch_e              ex_branch;
  logic [EXC_WIDTH-1:0] ex_exc;
  data_t                ex_rs1_val;
  data_t                ex_rs2_val;
  data_t                ex_b;
  branch_e              ex_br_kind;
  logic                 ex_load;
  data_t                ex_result;
  data_t                ex_target;
  logic                 ex_redirect;

  // MEM
  logic                 mem_valid;
  reg_idx_t             mem_rd;
  logic                 mem_reg_we;
  logic                 mem_load;
  logic                 mem_store;
  data_t                mem_result;
  data_t                mem_wdata;
  logic [EXC_WIDTH-1:0] mem_exc;
  logic [EXC_WIDTH-1:0] mem_exc_all;
  logic                 mem_we;
  logic                 mem_rd_en;
  logic                 mem_wr_en;
  logic                 data_fault;
  data_t                mem_rdata;

  // WB
  logic     wb_valid;
  reg_idx_t wb_rd;
  logic     wb_reg_we;
  logic     wb_load;
  data_t    wb_alu;
  data_t    wb_data;
  logic     wb_we;

  function automatic data_t fwd_pick(fwd_sel_e sel, data_t reg_val, data_t mem_val,
                                     data_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  mem_control #(
    .MEM_WORDS(MEM_WORDS)
  ) u_mem (
    .clk_i       (clk_i),
    .pc_i        (pc_i),
    .addr_i      (mem_result),
    .wdata_i     (mem_wdata),
    .rd_en_i     (mem_rd_en),
    .wr_en_i     (mem_wr_en),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .inst_o      (inst_raw),
    .rdata_o     (mem_rdata),
    .inst_fault_o(inst_fault),
    .data_fault_o(data_fault)
  );

  // ==============================
  // IF/ID
  // ==============================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stall_q    <= 1'b0;
      flush_q    <= 1'b0;
      id_valid_q <= 1'b0;
    end else begin
      stall_q <= stall;
      flush_q <= flush;
      if (!stall) begin
        id_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      id_pc_q    <= pc_i;
      id_fault_q <= inst_fault;
    end
    id_hold_q <= id_inst;
  end

  // Memory output keeps moving during a stall, so replay the held word
  assign id_inst  = flush_q ? NOP_INST : (stall_q ? id_hold_q : inst_raw);
  assign id_valid = id_valid_q & ~flush_q;

  idu u_idu (
    .inst_i        (id_inst),
    .rs1_o         (id_rs1),
    .rs2_o         (id_rs2),
    .rd_o          (id_rd),
    .use_rs1_o     (id_use_rs1),
    .use_rs2_o     (id_use_rs2),
    .reg_we_o      (id_reg_we),
    .mem_rd_o      (id_mem_rd),
    .mem_wr_o      (id_mem_wr),
    .alu_src_imm_o (id_alu_src_imm),
    .alu_op_o      (id_alu_op),
    .branch_o      (id_branch),
    .imm_o         (id_imm),
    .decode_error_o(id_decode_error),
    .ecall_o       (id_ecall),
    .ebreak_o      (id_ebreak)
  );

  gpr u_gpr (
    .clk_i     (clk_i),
    .rs1_i     (id_rs1),
    .rs2_i     (id_rs2),
    .rd_i      (wb_rd),
    .we_i      (wb_we),
    .wdata_i   (wb_data),
    .rs1_data_o(id_rs1_data),
    .rs2_data_o(id_rs2_data)
  );

  always_comb begin
    id_exc             = '0;
    id_exc[EXC_FETCH]  = id_fault_q;
    id_exc[EXC_DECODE] = id_decode_error;
    id_exc[EXC_ECALL]  = id_ecall;
    id_exc[EXC_EBREAK] = id_ebreak;
  end

  // ==============================
  // ID/EX
  // ==============================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_valid <= 1'b0;
    end else begin
      // Bubble on a load-use stall or a mispredict
      ex_valid <= id_valid & ~stall & ~flush;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_pc          <= id_pc_q;
    ex_imm         <= id_imm;
    ex_rs1_data    <= id_rs1_data;
    ex_rs2_data    <= id_rs2_data;
    ex_rs1         <= id_rs1;
    ex_rs2         <= id_rs2;
    ex_rd          <= id_rd;
    ex_use_rs1     <= id_use_rs1;
    ex_use_rs2     <= id_use_rs2;
    ex_reg_we      <= id_reg_we;
    ex_mem_rd      <= id_mem_rd;
    ex_mem_wr      <= id_mem_wr;
    ex_alu_src_imm <= id_alu_src_imm;
    ex_alu_op      <= id_alu_op;
    ex_branch      <= id_branch;
    ex_exc         <= id_exc;
  end

  // ==============================
  // EX
  // ==============================
  assign ex_rs1_val = fwd_pick(fwd_a, ex_rs1_data, mem_result, wb_data);
  assign ex_rs2_val = fwd_pick(fwd_b, ex_rs2_data, mem_result, wb_data);
  assign ex_b       = ex_alu_src_imm ? ex_imm : ex_rs2_val;
  assign ex_br_kind = ex_valid ? ex_branch : BR_NONE;
  assign ex_load    = ex_valid & ex_mem_rd;

  exec_unit u_exec (
    .a_i       (ex_rs1_val),
    .b_i       (ex_b),
    .alu_op_i  (ex_alu_op),
    .branch_i  (ex_br_kind),
    .pc_i      (ex_pc),
    .imm_i     (ex_imm),
    .rs1_val_i (ex_rs1_val),
    .rs2_val_i (ex_rs2_val),
    .result_o  (ex_result),
    .redirect_o(ex_redirect),
    .target_o  (ex_target)
  );

  hazard_unit u_hazard (
    .ex_rs1_i    (ex_rs1),
    .ex_rs2_i    (ex_rs2),
    .ex_use_rs1_i(ex_use_rs1),
    .ex_use_rs2_i(ex_use_rs2),
    .mem_rd_i    (mem_rd),
    .mem_we_i    (mem_we),
    .wb_rd_i     (wb_rd),
    .wb_we_i     (wb_we),
    .ex_load_i   (ex_load),
    .ex_rd_i     (ex_rd),
    .id_rs1_i    (id_rs1),
    .id_rs2_i    (id_rs2),
    .id_use_rs1_i(id_use_rs1),
    .id_use_rs2_i(id_use_rs2),
    .redirect_i  (ex_redirect),
    .fwd_a_o     (fwd_a),
    .fwd_b_o     (fwd_b),
    .stall_o     (stall),
    .flush_o     (flush)
  );

  // Predict not-taken, fix up from EX
  assign new_pc_o = flush ? ex_target : (stall ? pc_i : pc_i + data_t'(4));

  // ==============================
  // EX/MEM and MEM
  // ==============================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    mem_rd     <= ex_rd;
    mem_reg_we <= ex_reg_we;
    mem_load   <= ex_mem_rd;
    mem_store  <= ex_mem_wr;
    mem_result <= ex_result;
    mem_wdata  <= ex_rs2_val;
    mem_exc    <= ex_exc;
  end

  assign mem_rd_en = mem_valid & mem_load;
  assign mem_wr_en = mem_valid & mem_store;
  assign mem_we    = mem_valid & mem_reg_we;

  always_comb begin
    mem_exc_all          = mem_exc;
    mem_exc_all[EXC_MEM] = data_fault;
  end

  // ==============================
  // MEM/WB and WB
  // ==============================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_valid     <= 1'b0;
      exceptions_o <= '0;
    end else begin
      wb_valid     <= mem_valid;
      // MEM is past every flush point, so reports come out in program order
      exceptions_o <= mem_valid ? mem_exc_all : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd     <= mem_rd;
    wb_reg_we <= mem_reg_we & ~data_fault;
    wb_load   <= mem_load;
    wb_alu    <= mem_result;
  end

  // Load data arrives from the synchronous read port in this cycle
  assign wb_data = wb_load ? mem_rdata : wb_alu;
  assign wb_we   = wb_valid & wb_reg_we & (wb_rd != '0);

  assign wb_valid_o = wb_we;
  assign wb_rd_o    = wb_rd;
  assign wb_data_o  = wb_data;

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
  import cpu_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 prog_we_i,
  input  data_t                prog_addr_i,
  input  inst_t                prog_data_i,
  output logic                 wb_valid_o,
  output reg_idx_t             wb_rd_o,
  output data_t                wb_data_o,
  output logic [EXC_WIDTH-1:0] exceptions_o
);

  data_t pc;
  data_t new_pc;

  // Architectural fetch PC, the core decides where it goes next
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc <= '0;
    end else begin
      pc <= new_pc;
    end
  end

  cpu_core #(
    .MEM_WORDS(MEM_WORDS)
  ) u_core (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .pc_i        (pc),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .new_pc_o    (new_pc),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o),
    .exceptions_o(exceptions_o)
  );

endmodule

// ==== verif/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker
  import cpu_pkg::*;
(
  input logic     clk_i,
  input logic     rst_i,
  input logic     stall_i,
  input logic     flush_i,
  input logic     ex_valid_i,
  input logic     mem_valid_i,
  input logic     wb_valid_i,
  input data_t    pc_i,
  input reg_idx_t mem_rd_i,
  input logic     wb_we_i
);

  a_valid_known: assert property (@(posedge clk_i) disable iff (rst_i)
    (stall_i || flush_i) |=> !$isunknown({ex_valid_i, mem_valid_i, wb_valid_i}))
    else $error("stage valid bit unknown after a stall or flush");

  // Load-use bubble keeps the fetch address in the PC register
  a_pc_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (stall_i && !flush_i) |=> $stable(pc_i))
    else $error("PC moved during a stall without a redirect");

  // An instruction aimed at x0 leaves MEM without a register write
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
    (mem_valid_i && mem_rd_i == '0) |=> !wb_we_i)
    else $error("write-back targets x0");

endmodule

bind cpu_core cpu_checker u_checker (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .stall_i    (stall),
  .flush_i    (flush),
  .ex_valid_i (ex_valid),
  .mem_valid_i(mem_valid),
  .wb_valid_i (wb_valid),
  .pc_i       (pc_i),
  .mem_rd_i   (mem_rd),
  .wb_we_i    (wb_we)
);

// ==== verif/cpu_monitor.sv ====
`timescale 1ns/1ps

module cpu_monitor
  import cpu_pkg::*;
#(
  parameter int RET_N = 15,
  parameter int EXC_N = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 wb_valid_i,
  input  reg_idx_t             wb_rd_i,
  input  data_t                wb_data_i,
  input  logic [EXC_WIDTH-1:0] exceptions_i,
  input  reg_idx_t             exp_rd_i [RET_N],
  input  data_t                exp_data_i [RET_N],
  input  logic [2:0]           exp_exc_i [EXC_N],
  output logic                 done_o,
  output int                   pass_count_o,
  output int                   fail_count_o
);

  int ret_idx = 0;
  int exc_idx = 0;
  int passes = 0;
  int fails = 0;

  task automatic check_retire();
    if (ret_idx >= RET_N) begin
      $display("FAIL %0t: extra write-back x%0d = %08h", $time, wb_rd_i, wb_data_i);
      fails++;
    end else if (wb_rd_i == exp_rd_i[ret_idx] && wb_data_i == exp_data_i[ret_idx]) begin
      $display("PASS retire %0d: x%0d = %08h", ret_idx, wb_rd_i, wb_data_i);
      passes++;
      ret_idx++;
    end else begin
      $display("FAIL %0t: retire %0d expected x%0d = %08h, got x%0d = %08h", $time, ret_idx,
               exp_rd_i[ret_idx], exp_data_i[ret_idx], wb_rd_i, wb_data_i);
      fails++;
      ret_idx++;
    end
  endtask

  task automatic check_exception();
    logic [EXC_WIDTH-1:0] want;
    want = '0;
    if (exc_idx >= EXC_N) begin
      $display("FAIL %0t: unexpected exception vector %05b", $time, exceptions_i);
      fails++;
      return;
    end
    want[exp_exc_i[exc_idx]] = 1'b1;
    if (exceptions_i == want) begin
      $display("PASS exception %0d: vector %05b", exc_idx, exceptions_i);
      passes++;
    end else begin
      $display("FAIL %0t: exception %0d expected %05b, got %05b", $time, exc_idx, want,
               exceptions_i);
      fails++;
    end
    exc_idx++;
  endtask

  // Sample mid-cycle, well away from the DUT's clock edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      if (wb_valid_i || exceptions_i != '0) begin
        $display("FAIL %0t: retire or exception output active during reset", $time);
        fails++;
      end
    end else begin
      if (wb_valid_i) begin
        check_retire();
      end
      if (exceptions_i != '0) begin
        check_exception();
      end
    end
  end

  assign done_o       = (ret_idx >= RET_N) && (exc_idx >= EXC_N);
  assign pass_count_o = passes;
  assign fail_count_o = fails;

endmodule

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb
  import cpu_pkg::*;
;

  localparam int PROG_LEN = 30;
  localparam int RET_N    = 15;
  localparam int EXC_N    = 4;
  localparam int LIMIT    = PROG_LEN * 4 + 50;

  logic                 clk_i;
  logic                 rst_i;
  logic                 prog_we_i;
  data_t                prog_addr_i;
  inst_t                prog_data_i;
  logic                 wb_valid_o;
  reg_idx_t             wb_rd_o;
  data_t                wb_data_o;
  logic [EXC_WIDTH-1:0] exceptions_o;

  inst_t      prog [PROG_LEN];
  reg_idx_t   exp_rd [RET_N];
  data_t      exp_data [RET_N];
  logic [2:0] exp_exc [EXC_N];
  logic       done;
  int         pass_count;
  int         fail_count;
  int         cycles = 0;
  logic       timed_out;
  logic [11:0] r1;
  logic [11:0] r2;
  data_t      x1;
  data_t      x2;
  data_t      x3;
  data_t      x4;
  data_t      x5;
  data_t      x6;
  data_t      x7;

  cpu_top #(
    .MEM_WORDS(256)
  ) UUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o),
    .exceptions_o(exceptions_o)
  );

  cpu_monitor #(
    .RET_N(RET_N),
    .EXC_N(EXC_N)
  ) u_monitor (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wb_valid_i  (wb_valid_o),
    .wb_rd_i     (wb_rd_o),
    .wb_data_i   (wb_data_o),
    .exceptions_i(exceptions_o),
    .exp_rd_i    (exp_rd),
    .exp_data_i  (exp_data),
    .exp_exc_i   (exp_exc),
    .done_o      (done),
    .pass_count_o(pass_count),
    .fail_count_o(fail_count)
  );

  // ==============================
  // Instruction encoders
  // ==============================
  function automatic inst_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                   reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic inst_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic inst_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic inst_t j_type(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (!rst_i) begin
      cycles <= cycles + 1;
    end
  end

  initial begin
    rst_i       = 1'b1;
    prog_we_i   = 1'b0;
    prog_addr_i = '0;
    prog_data_i = '0;
    void'($urandom(44579));
    r1          = 12'($urandom);
    r2          = 12'($urandom);

    // ==============================
    // Program words at byte address index * 4
    // ==============================
    prog[0]  = i_type(r1, 5'd0, 3'b000, 5'd1, 7'h13);
    prog[1]  = i_type(r2, 5'd1, 3'b000, 5'd2, 7'h13);
    prog[2]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
    prog[3]  = r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);
    prog[4]  = r_type(7'h00, 5'd3, 5'd4, 3'b111, 5'd5);
    prog[5]  = r_type(7'h00, 5'd2, 5'd5, 3'b110, 5'd6);
    prog[6]  = r_type(7'h00, 5'd1, 5'd6, 3'b100, 5'd7);
    prog[7]  = r_type(7'h00, 5'd3, 5'd1, 3'b010, 5'd8);
    prog[8]  = i_type(12'd256, 5'd0, 3'b000, 5'd10, 7'h13);
    prog[9]  = s_type(12'd0, 5'd7, 5'd10);
    prog[10] = i_type(12'd0, 5'd10, 3'b010, 5'd11, 7'h03);
    prog[11] = r_type(7'h00, 5'd1, 5'd11, 3'b000, 5'd12);
    // Taken BEQ skips an ADDI and an ECALL
    prog[12] = b_type(13'd12, 5'd1, 5'd1, 3'b000);
    prog[13] = i_type(12'd1, 5'd0, 3'b000, 5'd13, 7'h13);
    prog[14] = 32'h0000_0073;
    prog[15] = b_type(13'd8, 5'd1, 5'd1, 3'b001);
    prog[16] = j_type(21'd12, 5'd14);
    prog[17] = i_type(12'd2, 5'd0, 3'b000, 5'd13, 7'h13);
    prog[18] = i_type(12'd3, 5'd0, 3'b000, 5'd13, 7'h13);
    prog[19] = i_type(12'd96, 5'd0, 3'b000, 5'd15, 7'h13);
    prog[20] = i_type(12'd0, 5'd15, 3'b000, 5'd16, 7'h67);
    prog[21] = i_type(12'd4, 5'd0, 3'b000, 5'd13, 7'h13);
    prog[22] = i_type(12'd5, 5'd0, 3'b000, 5'd13, 7'h13);
    prog[23] = i_type(12'd6, 5'd0, 3'b000, 5'd13, 7'h13);
    prog[24] = 32'h0000_0073;
    prog[25] = 32'h0010_0073;
    prog[26] = 32'hffff_ffff;
    prog[27] = i_type(12'd2, 5'd10, 3'b010, 5'd17, 7'h03);
    prog[28] = i_type(12'd7, 5'd0, 3'b000, 5'd18, 7'h13);
    prog[29] = j_type(21'd0, 5'd0);

    // Architectural results in program order
    x1 = {{20{r1[11]}}, r1};
    x2 = x1 + {{20{r2[11]}}, r2};
    x3 = x1 + x2;
    x4 = x3 - x1;
    x5 = x4 & x3;
    x6 = x5 | x2;
    x7 = x6 ^ x1;
    exp_rd[0]    = 5'd1;
    exp_data[0]  = x1;
    exp_rd[1]    = 5'd2;
    exp_data[1]  = x2;
    exp_rd[2]    = 5'd3;
    exp_data[2]  = x3;
    exp_rd[3]    = 5'd4;
    exp_data[3]  = x4;
    exp_rd[4]    = 5'd5;
    exp_data[4]  = x5;
    exp_rd[5]    = 5'd6;
    exp_data[5]  = x6;
    exp_rd[6]    = 5'd7;
    exp_data[6]  = x7;
    exp_rd[7]    = 5'd8;
    exp_data[7]  = ($signed(x1) < $signed(x3)) ? 32'd1 : 32'd0;
    exp_rd[8]    = 5'd10;
    exp_data[8]  = 32'd256;
    exp_rd[9]    = 5'd11;
    exp_data[9]  = x7;
    exp_rd[10]   = 5'd12;
    exp_data[10] = x7 + x1;
    exp_rd[11]   = 5'd14;
    exp_data[11] = 32'd68;
    exp_rd[12]   = 5'd15;
    exp_data[12] = 32'd96;
    exp_rd[13]   = 5'd16;
    exp_data[13] = 32'd84;
    exp_rd[14]   = 5'd18;
    exp_data[14] = 32'd7;
    exp_exc[0] = 3'(EXC_ECALL);
    exp_exc[1] = 3'(EXC_EBREAK);
    exp_exc[2] = 3'(EXC_DECODE);
    exp_exc[3] = 3'(EXC_MEM);

    for (int i = 0; i < PROG_LEN; i++) begin
      @(posedge clk_i);
      prog_we_i   <= 1'b1;
      prog_addr_i <= data_t'(i * 4);
      prog_data_i <= prog[i];
    end
    @(posedge clk_i);
    prog_we_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    while (!done && cycles < LIMIT) begin
      @(posedge clk_i);
    end
    timed_out = !done;
    if (timed_out) begin
      $display("Timeout: the expected retirements never completed within %0d cycles", LIMIT);
    end else begin
      // Let any stray retirement or exception show up
      repeat (8) @(posedge clk_i);
    end

    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (!timed_out && fail_count == 0 && pass_count == RET_N + EXC_N) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
common/cpu_pkg.sv
hw/mem_control.sv
core/gpr.sv
core/idu.sv
core/exec_unit.sv
core/hazard_unit.sv
core/cpu_core.sv
hw/cpu_top.sv
verif/cpu_checker.sv
verif/cpu_monitor.sv
verif/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and check the log for a pass"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
